// ==== project.f ====
+incdir+src
src/rs_pkg.sv
src/rs_entry.sv
src/rs_alloc.sv
src/rs_issue_select.sv
src/rs_top.sv
testbench/tb_rs_assertions.sv
testbench/tb_rs.sv

// ==== Makefile ====
# Verilator build and run of the reservation station testbench

BIN  := obj_dir/Vtb_rs
SRCS := $(filter-out +%,$(shell cat project.f))

.PHONY: all run clean

all: run

# Rebuilt only when a source, the header or the file list changes
$(BIN): project.f src/rs_cfg.svh $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_rs -o Vtb_rs

# Pass only when the simulator printed the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

// ==== testbench/tb_rs.sv ====
// Directed testbench for the reservation station
// Clock, reset, watchdog, slot-level reference model and test tasks

`timescale 1ns/1ps
`default_nettype none

`include "rs_cfg.svh"

module tb_rs;

	import rs_pkg::*;

	localparam int CLK_PERIOD = 8;
	// Six short tests, well under a hundred cycles together
	localparam int WATCHDOG_CYCLES = 2000;
	localparam int NE = `RS_NUM_ENTRY;
	localparam int NF = `RS_NUM_FU;
	localparam int CLASS_SIZE [NF] = '{`RS_NUM_LD, `RS_NUM_ST, `RS_NUM_BR, `RS_NUM_MULT, `RS_NUM_ALU};

	logic clock;
	logic arst_n;
	logic dispatch_valid;
	fu_t dispatch_fu;
	alu_func_t dispatch_func;
	logic [TAG_W-1:0] dispatch_dest, dispatch_src1, dispatch_src2;
	logic dispatch_src1_ready, dispatch_src2_ready;
	logic cdb_valid;
	logic [TAG_W-1:0] cdb_tag;
	logic [NF-1:0] rs_full;
	logic [NF-1:0] issue_valid;
	alu_func_t [NF-1:0] issue_func;
	logic [NF-1:0][TAG_W-1:0] issue_dest, issue_src1, issue_src2;

	// Reference model, one record per slot
	logic m_busy [NE];
	logic m_rdy1 [NE];
	logic m_rdy2 [NE];
	logic [4:0] m_func [NE];
	logic [TAG_W-1:0] m_dest [NE];
	logic [TAG_W-1:0] m_src1 [NE];
	logic [TAG_W-1:0] m_src2 [NE];

	// Predicted outputs for the cycle after each edge
	logic [NF-1:0] exp_valid;
	logic [NF-1:0] exp_full;
	logic [4:0] exp_func [NF];
	logic [TAG_W-1:0] exp_dest [NF];
	logic [TAG_W-1:0] exp_src1 [NF];
	logic [TAG_W-1:0] exp_src2 [NF];

	logic [31:0] lfsr_state;

	rs_top u_dut (.*);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Verification failed");
		$fatal(1);
	end

	////////////////////////////////
	// Helpers
	////////////////////////////////

	task automatic check_eq(input string name, input longint unsigned act,
			input longint unsigned exp);
		assert (act == exp) else begin
			$display("FAILED at %0t: %s expected %0h got %0h", $time, name, exp, act);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	// First slot of a class, groups packed in class order
	function automatic int class_base(input int c);
		int base;
		base = 0;
		for (int k = 0; k < c; k++)
			base += CLASS_SIZE[k];
		return base;
	endfunction

	function automatic int slots_in_use();
		int n;
		n = 0;
		for (int i = 0; i < NE; i++)
			n += int'(m_busy[i]);
		return n;
	endfunction

	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	function automatic int unsigned rand_bits(input int n);
		int unsigned v;
		v = 0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = (v << 1) | lfsr_state[0];
		end
		return v;
	endfunction

	function automatic alu_func_t rand_func();
		return alu_func_t'(rand_bits(5) % 17);
	endfunction

	// Low half only, high tags are kept for pending sources
	function automatic logic [TAG_W-1:0] rand_tag();
		return TAG_W'(rand_bits(TAG_W - 1));
	endfunction

	////////////////////////////////
	// Reference model and checker
	////////////////////////////////

	always @(posedge clock or negedge arst_n) begin
		int alloc;
		int base;
		int s;
		if (!arst_n) begin
			for (int i = 0; i < NE; i++)
				m_busy[i] = 1'b0;
			exp_valid = '0;
			exp_full = '0;
		end else begin
			// Lowest free slot, from occupancy before this edge
			alloc = -1;
			if (dispatch_valid) begin
				base = class_base(int'(dispatch_fu));
				for (int k = CLASS_SIZE[dispatch_fu] - 1; k >= 0; k--)
					if (!m_busy[base + k])
						alloc = base + k;
			end
			// Lowest ready slot of each class issues and frees
			for (int c = 0; c < NF; c++) begin
				base = class_base(c);
				exp_valid[c] = 1'b0;
				for (int k = 0; k < CLASS_SIZE[c]; k++) begin
					s = base + k;
					if (!exp_valid[c] && m_busy[s] && m_rdy1[s] && m_rdy2[s]) begin
						exp_valid[c] = 1'b1;
						exp_func[c] = m_func[s];
						exp_dest[c] = m_dest[s];
						exp_src1[c] = m_src1[s];
						exp_src2[c] = m_src2[s];
						m_busy[s] = 1'b0;
					end
				end
			end
			// CDB wakeup
			for (int i = 0; i < NE; i++) begin
				if (cdb_valid && m_src1[i] == cdb_tag)
					m_rdy1[i] = 1'b1;
				if (cdb_valid && m_src2[i] == cdb_tag)
					m_rdy2[i] = 1'b1;
			end
			if (alloc >= 0) begin
				m_busy[alloc] = 1'b1;
				m_func[alloc] = dispatch_func;
				m_dest[alloc] = dispatch_dest;
				m_src1[alloc] = dispatch_src1;
				m_src2[alloc] = dispatch_src2;
				m_rdy1[alloc] = dispatch_src1_ready || (cdb_valid && cdb_tag == dispatch_src1);
				m_rdy2[alloc] = dispatch_src2_ready || (cdb_valid && cdb_tag == dispatch_src2);
			end
			for (int c = 0; c < NF; c++) begin
				base = class_base(c);
				exp_full[c] = 1'b1;
				for (int k = 0; k < CLASS_SIZE[c]; k++)
					if (!m_busy[base + k])
						exp_full[c] = 1'b0;
			end
		end
	end

	// Mid-cycle compare against the model
	always @(negedge clock) begin
		if (arst_n) begin
			check_eq("rs_full", rs_full, exp_full);
			check_eq("issue_valid", issue_valid, exp_valid);
			for (int c = 0; c < NF; c++) begin
				if (exp_valid[c]) begin
					check_eq($sformatf("issue_func[%0d]", c), issue_func[c], exp_func[c]);
					check_eq($sformatf("issue_dest[%0d]", c), issue_dest[c], exp_dest[c]);
					check_eq($sformatf("issue_src1[%0d]", c), issue_src1[c], exp_src1[c]);
					check_eq($sformatf("issue_src2[%0d]", c), issue_src2[c], exp_src2[c]);
				end
			end
		end
	end

	////////////////////////////////
	// Drivers
	////////////////////////////////

	task automatic step(input int n);
		repeat (n) @(posedge clock);
		#1;
	endtask

	// One-cycle dispatch strobe, also ends any CDB strobe set up with it
	task automatic dispatch(input fu_t fu, input alu_func_t func, input logic [TAG_W-1:0] dest,
			input logic [TAG_W-1:0] s1, input logic r1,
			input logic [TAG_W-1:0] s2, input logic r2);
		dispatch_valid = 1'b1;
		dispatch_fu = fu;
		dispatch_func = func;
		dispatch_dest = dest;
		dispatch_src1 = s1;
		dispatch_src1_ready = r1;
		dispatch_src2 = s2;
		dispatch_src2_ready = r2;
		step(1);
		dispatch_valid = 1'b0;
		cdb_valid = 1'b0;
	endtask

	task automatic broadcast(input logic [TAG_W-1:0] tag);
		cdb_valid = 1'b1;
		cdb_tag = tag;
		step(1);
		cdb_valid = 1'b0;
	endtask

	task automatic expect_issue(input int c, input alu_func_t func,
			input logic [TAG_W-1:0] dest, s1, s2);
		check_eq($sformatf("issue_valid[%0d]", c), issue_valid[c], 1);
		check_eq($sformatf("issue_func[%0d]", c), issue_func[c], func);
		check_eq($sformatf("issue_dest[%0d]", c), issue_dest[c], dest);
		check_eq($sformatf("issue_src1[%0d]", c), issue_src1[c], s1);
		check_eq($sformatf("issue_src2[%0d]", c), issue_src2[c], s2);
	endtask

	// No issue on class c for n cycles
	task automatic idle_for(input int c, input int n);
		repeat (n) begin
			step(1);
			check_eq($sformatf("issue_valid[%0d]", c), issue_valid[c], 0);
		end
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while (slots_in_use() != 0 || issue_valid != '0) begin
			step(1);
			cycles++;
			assert (cycles < 20) else begin
				$display("Station still holds instructions after 20 cycles");
				$display("Verification failed");
				$fatal(1);
			end
		end
	endtask

	////////////////////////////////
	// Tests
	////////////////////////////////

	task automatic test_reset_state();
		check_eq("issue_valid", issue_valid, 0);
		check_eq("rs_full", rs_full, 0);
	endtask

	// Both sources ready, one instruction per class
	task automatic test_ready_issue();
		alu_func_t f;
		logic [TAG_W-1:0] d, s1, s2;
		for (int c = 0; c < NF; c++) begin
			f = rand_func();
			d = rand_tag();
			s1 = rand_tag();
			s2 = rand_tag();
			dispatch(fu_t'(c), f, d, s1, 1'b1, s2, 1'b1);
			check_eq($sformatf("issue_valid[%0d]", c), issue_valid[c], 0);
			step(1);
			expect_issue(c, f, d, s1, s2);
			idle_for(c, 1);
		end
	endtask

	task automatic test_wakeup();
		alu_func_t f;
		logic [TAG_W-1:0] d, s1;
		f = rand_func();
		d = rand_tag();
		s1 = rand_tag();
		dispatch(fu_alu, f, d, s1, 1'b1, 6'd45, 1'b0);
		idle_for(fu_alu, 3);
		broadcast(6'd46);
		idle_for(fu_alu, 3);
		broadcast(6'd45);
		check_eq("issue_valid[4]", issue_valid[fu_alu], 0);
		step(1);
		expect_issue(fu_alu, f, d, s1, 6'd45);
		wait_drained();
	endtask

	task automatic test_full();
		alu_func_t f [3];
		logic [TAG_W-1:0] d [3];
		logic [TAG_W-1:0] s2 [3];
		for (int k = 0; k < 3; k++) begin
			f[k] = rand_func();
			d[k] = rand_tag();
			s2[k] = rand_tag();
			dispatch(fu_alu, f[k], d[k], TAG_W'(50 + k), 1'b0, s2[k], 1'b1);
			check_eq("rs_full", rs_full, (k == 2) ? (NF'(1) << fu_alu) : 0);
		end
		// Middle slot wakes first
		broadcast(6'd51);
		check_eq("rs_full", rs_full, NF'(1) << fu_alu);
		step(1);
		expect_issue(fu_alu, f[1], d[1], 6'd51, s2[1]);
		check_eq("rs_full", rs_full, 0);
		broadcast(6'd50);
		broadcast(6'd52);
		wait_drained();
	endtask

	// Three ALU, one MULT and one BR all wait on tag 55
	task automatic test_order();
		fu_t cls [5];
		alu_func_t f [5];
		logic [TAG_W-1:0] d [5];
		logic [TAG_W-1:0] s2 [5];
		cls = '{fu_alu, fu_alu, fu_alu, fu_mult, fu_br};
		for (int k = 0; k < 5; k++) begin
			f[k] = rand_func();
			d[k] = rand_tag();
			s2[k] = rand_tag();
			dispatch(cls[k], f[k], d[k], 6'd55, 1'b0, s2[k], 1'b1);
		end
		broadcast(6'd55);
		step(1);
		expect_issue(fu_alu, f[0], d[0], 6'd55, s2[0]);
		expect_issue(fu_mult, f[3], d[3], 6'd55, s2[3]);
		expect_issue(fu_br, f[4], d[4], 6'd55, s2[4]);
		step(1);
		expect_issue(fu_alu, f[1], d[1], 6'd55, s2[1]);
		check_eq("issue_valid[3]", issue_valid[fu_mult], 0);
		step(1);
		expect_issue(fu_alu, f[2], d[2], 6'd55, s2[2]);
		idle_for(fu_alu, 1);
		wait_drained();
	endtask

	// Both sources match the CDB tag in the dispatch cycle
	task automatic test_bypass();
		alu_func_t f;
		logic [TAG_W-1:0] d;
		f = rand_func();
		d = rand_tag();
		cdb_valid = 1'b1;
		cdb_tag = 6'd58;
		dispatch(fu_ld, f, d, 6'd58, 1'b0, 6'd58, 1'b0);
		check_eq("issue_valid[0]", issue_valid[fu_ld], 0);
		step(1);
		expect_issue(fu_ld, f, d, 6'd58, 6'd58);
		wait_drained();
	endtask

	initial begin
		lfsr_state = 32'h2be9b354;
		arst_n = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_fu = fu_ld;
		dispatch_func = alu_addq;
		dispatch_dest = '0;
		dispatch_src1 = '0;
		dispatch_src1_ready = 1'b0;
		dispatch_src2 = '0;
		dispatch_src2_ready = 1'b0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		step(5);
		arst_n = 1'b1;
		step(1);
		test_reset_state();
		test_ready_issue();
		test_wakeup();
		test_full();
		test_order();
		test_bypass();
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/tb_rs_assertions.sv ====
// Concurrent checks bound into the reservation station top level
// Dispatch legality, per-class free one-hot, no issue right after reset

`timescale 1ns/1ps
`default_nettype none

`include "rs_cfg.svh"

module tb_rs_assertions (
	input logic                     clock,
	input logic                     arst_n,
	input logic                     dispatch_valid,
	input rs_pkg::fu_t              dispatch_fu,
	input logic [`RS_NUM_FU-1:0]    rs_full,
	input logic [`RS_NUM_ENTRY-1:0] free_sel,
	input logic [`RS_NUM_FU-1:0]    issue_valid
);

	localparam int CLASS_SIZE [`RS_NUM_FU] = '{
		`RS_NUM_LD, `RS_NUM_ST, `RS_NUM_BR, `RS_NUM_MULT, `RS_NUM_ALU
	};

	// Slots owned by class c
	function automatic logic [`RS_NUM_ENTRY-1:0] class_mask(input int c);
		logic [`RS_NUM_ENTRY-1:0] mask;
		int base;
		mask = '0;
		base = 0;
		for (int k = 0; k < c; k++)
			base += CLASS_SIZE[k];
		for (int k = 0; k < CLASS_SIZE[c]; k++)
			mask[base + k] = 1'b1;
		return mask;
	endfunction

	// Upstream honors the full flags
	assert property (@(posedge clock) disable iff (!arst_n)
		dispatch_valid |-> !rs_full[dispatch_fu])
	else $error("dispatch into a full class");

	for (genvar c = 0; c < `RS_NUM_FU; c++) begin : g_free
		assert property (@(posedge clock) disable iff (!arst_n)
			$onehot0(free_sel & class_mask(c)))
		else $error("more than one slot freed in class %0d", c);
	end

	// No stale slot issues on the first edge out of reset
	assert property (@(posedge clock) $rose(arst_n) |=> issue_valid == '0)
	else $error("issue in the first cycle after reset");

endmodule

bind rs_top tb_rs_assertions u_assertions (
	.clock          (clock),
	.arst_n         (arst_n),
	.dispatch_valid (dispatch_valid),
	.dispatch_fu    (dispatch_fu),
	.rs_full        (rs_full),
	.free_sel       (free_sel),
	.issue_valid    (issue_valid)
);

`default_nettype wire

// ==== src/rs_top.sv ====
// Reservation station top level
// Allocator, slot array and issue selector

`timescale 1ns/1ps
`default_nettype none

`include "rs_cfg.svh"

module rs_top (
	input  logic                                         clock,
	input  logic                                         arst_n,
	// Dispatch
	input  logic                                         dispatch_valid,
	input  rs_pkg::fu_t                                  dispatch_fu,
	input  rs_pkg::alu_func_t                            dispatch_func,
	input  logic              [rs_pkg::TAG_W-1:0]        dispatch_dest,
	input  logic              [rs_pkg::TAG_W-1:0]        dispatch_src1,
	input  logic                                         dispatch_src1_ready,
	input  logic              [rs_pkg::TAG_W-1:0]        dispatch_src2,
	input  logic                                         dispatch_src2_ready,
	// CDB
	input  logic                                         cdb_valid,
	input  logic              [rs_pkg::TAG_W-1:0]        cdb_tag,
	// Occupancy per class
	output logic              [`RS_NUM_FU-1:0]           rs_full,
	// Issue per class
	output logic              [`RS_NUM_FU-1:0]                     issue_valid,
	output rs_pkg::alu_func_t [`RS_NUM_FU-1:0]                     issue_func,
	output logic              [`RS_NUM_FU-1:0][rs_pkg::TAG_W-1:0] issue_dest,
	output logic              [`RS_NUM_FU-1:0][rs_pkg::TAG_W-1:0] issue_src1,
	output logic              [`RS_NUM_FU-1:0][rs_pkg::TAG_W-1:0] issue_src2
);

	import rs_pkg::*;

	// Slot handshakes
	logic [`RS_NUM_ENTRY-1:0] write_sel;
	logic [`RS_NUM_ENTRY-1:0] free_sel;
	logic [`RS_NUM_ENTRY-1:0] busy;
	logic [`RS_NUM_ENTRY-1:0] ready;

	// Slot payload toward the selector
	alu_func_t [`RS_NUM_ENTRY-1:0]            ent_func;
	logic      [`RS_NUM_ENTRY-1:0][TAG_W-1:0] ent_dest;
	logic      [`RS_NUM_ENTRY-1:0][TAG_W-1:0] ent_src1;
	logic      [`RS_NUM_ENTRY-1:0][TAG_W-1:0] ent_src2;

	////////////////////////////////
	// Allocation
	////////////////////////////////

	rs_alloc u_alloc (
		.dispatch_valid (dispatch_valid),
		.dispatch_fu    (dispatch_fu),
		.busy           (busy),
		.write_sel      (write_sel),
		.rs_full        (rs_full)
	);

	////////////////////////////////
	// Slot array
	////////////////////////////////

	// Dispatch fields fan out, write_sel picks the slot
	for (genvar i = 0; i < `RS_NUM_ENTRY; i++) begin : g_entry
		rs_entry u_entry (
			.clock         (clock),
			.arst_n        (arst_n),
			.write         (write_sel[i]),
			.free          (free_sel[i]),
			.in_func       (dispatch_func),
			.in_dest       (dispatch_dest),
			.in_src1       (dispatch_src1),
			.in_src2       (dispatch_src2),
			.in_src1_ready (dispatch_src1_ready),
			.in_src2_ready (dispatch_src2_ready),
			.cdb_valid     (cdb_valid),
			.cdb_tag       (cdb_tag),
			.busy          (busy[i]),
			.ready         (ready[i]),
			.func          (ent_func[i]),
			.dest          (ent_dest[i]),
			.src1          (ent_src1[i]),
			.src2          (ent_src2[i])
		);
	end

	////////////////////////////////
	// Issue
	////////////////////////////////

	rs_issue_select u_issue (
		.clock       (clock),
		.arst_n      (arst_n),
		.ready       (ready),
		.func        (ent_func),
		.dest        (ent_dest),
		.src1        (ent_src1),
		.src2        (ent_src2),
		.free_sel    (free_sel),
		.issue_valid (issue_valid),
		.issue_func  (issue_func),
		.issue_dest  (issue_dest),
		.issue_src1  (issue_src1),
		.issue_src2  (issue_src2)
	);

endmodule

`default_nettype wire

// ==== src/rs_issue_select.sv ====
// Issue selector
// Lowest ready slot per class, registered issue ports, free strobes

`timescale 1ns/1ps
`default_nettype none

`include "rs_cfg.svh"

module rs_issue_select (
	input  logic                                         clock,
	input  logic                                         arst_n,
	// Slot status and payload
	input  logic              [`RS_NUM_ENTRY-1:0]                     ready,
	input  rs_pkg::alu_func_t [`RS_NUM_ENTRY-1:0]                     func,
	input  logic              [`RS_NUM_ENTRY-1:0][rs_pkg::TAG_W-1:0] dest,
	input  logic              [`RS_NUM_ENTRY-1:0][rs_pkg::TAG_W-1:0] src1,
	input  logic              [`RS_NUM_ENTRY-1:0][rs_pkg::TAG_W-1:0] src2,
	// Release strobe back to the slots
	output logic              [`RS_NUM_ENTRY-1:0]                     free_sel,
	// Per-class issue ports
	output logic              [`RS_NUM_FU-1:0]                        issue_valid,
	output rs_pkg::alu_func_t [`RS_NUM_FU-1:0]                        issue_func,
	output logic              [`RS_NUM_FU-1:0][rs_pkg::TAG_W-1:0]    issue_dest,
	output logic              [`RS_NUM_FU-1:0][rs_pkg::TAG_W-1:0]    issue_src1,
	output logic              [`RS_NUM_FU-1:0][rs_pkg::TAG_W-1:0]    issue_src2
);

	import rs_pkg::*;

	// Slot index width
	localparam int IDX_W = $clog2(`RS_NUM_ENTRY);

	// Winner per class
	logic [`RS_NUM_FU-1:0]            pick_valid;
	logic [`RS_NUM_FU-1:0][IDX_W-1:0] pick_idx;

	////////////////////////////////
	// Priority pick
	////////////////////////////////

	always_comb begin
		fu_t c;
		pick_valid = '0;
		pick_idx   = '0;
		free_sel   = '0;
		// Ascending scan, first ready slot of each class wins
		for (int i = 0; i < `RS_NUM_ENTRY; i++) begin
			c = class_of(i);
			if (ready[i] && !pick_valid[c]) begin
				pick_valid[c] = 1'b1;
				pick_idx[c]   = IDX_W'(i);
				free_sel[i]   = 1'b1;
			end
		end
	end

	////////////////////////////////
	// Issue registers
	////////////////////////////////

	// Valid bits, one cycle after selection
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			issue_valid <= '0;
		else
			issue_valid <= pick_valid;
	end

	// Payload mux from the winning slot
	always_ff @(posedge clock) begin
		for (int c = 0; c < `RS_NUM_FU; c++) begin
			if (pick_valid[c]) begin
				issue_func[c] <= func[pick_idx[c]];
				issue_dest[c] <= dest[pick_idx[c]];
				issue_src1[c] <= src1[pick_idx[c]];
				issue_src2[c] <= src2[pick_idx[c]];
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/rs_alloc.sv ====
// Slot allocator for dispatch
// Lowest free slot of the dispatching class, per-class full flags

`timescale 1ns/1ps
`default_nettype none

`include "rs_cfg.svh"

module rs_alloc (
	// Dispatch request
	input  logic                     dispatch_valid,
	input  rs_pkg::fu_t              dispatch_fu,
	// Registered slot occupancy
	input  logic [`RS_NUM_ENTRY-1:0] busy,
	// One-hot slot grant
	output logic [`RS_NUM_ENTRY-1:0] write_sel,
	// One bit per class
	output logic [`RS_NUM_FU-1:0]    rs_full
);

	import rs_pkg::*;

	// Free slots belonging to the requested class
	logic [`RS_NUM_ENTRY-1:0] cand;

	// Lowest set bit of cand
	logic [`RS_NUM_ENTRY-1:0] cand_low;

	////////////////////////////////
	// Class mask
	////////////////////////////////

	always_comb begin
		cand = '0;
		for (int i = 0; i < `RS_NUM_ENTRY; i++) begin
			// Slot range check through the fixed grouping
			cand[i] = ~busy[i] && (class_of(i) == dispatch_fu);
		end
	end

	// Isolate the lowest free slot
	assign cand_low = cand & (~cand + 1'b1);

	// No grant without a strobe
	// Full class leaves cand empty, so the request drops
	assign write_sel = dispatch_valid ? cand_low : '0;

	////////////////////////////////
	// Full flags
	////////////////////////////////

	always_comb begin
		for (int c = 0; c < `RS_NUM_FU; c++) begin
			rs_full[c] = 1'b1;
			// Full only when every slot of the class is occupied
			for (int i = 0; i < `RS_NUM_ENTRY; i++) begin
				if (class_of(i) == fu_t'(c))
					rs_full[c] = rs_full[c] & busy[i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/rs_entry.sv ====
// Single reservation station slot
// Busy flag, payload tags, source ready bits, CDB wakeup

`timescale 1ns/1ps
`default_nettype none

`include "rs_cfg.svh"

module rs_entry (
	input  logic                     clock,
	input  logic                     arst_n,
	// Allocation and release strobes
	input  logic                     write,
	input  logic                     free,
	// Dispatched instruction
	input  rs_pkg::alu_func_t        in_func,
	input  logic [rs_pkg::TAG_W-1:0] in_dest,
	input  logic [rs_pkg::TAG_W-1:0] in_src1,
	input  logic [rs_pkg::TAG_W-1:0] in_src2,
	input  logic                     in_src1_ready,
	input  logic                     in_src2_ready,
	// Tag broadcast
	input  logic                     cdb_valid,
	input  logic [rs_pkg::TAG_W-1:0] cdb_tag,
	// Status
	output logic                     busy,
	output logic                     ready,
	// Stored payload
	output rs_pkg::alu_func_t        func,
	output logic [rs_pkg::TAG_W-1:0] dest,
	output logic [rs_pkg::TAG_W-1:0] src1,
	output logic [rs_pkg::TAG_W-1:0] src2
);

	// Per-source ready state
	logic src1_rdy;
	logic src2_rdy;

	// CDB hits on the incoming sources
	logic in_src1_hit;
	logic in_src2_hit;

	// CDB hits on the stored sources
	logic src1_hit;
	logic src2_hit;

	////////////////////////////////
	// Tag compare
	////////////////////////////////

	// Bypass path for a broadcast in the dispatch cycle
	assign in_src1_hit = cdb_valid && (cdb_tag == in_src1);
	assign in_src2_hit = cdb_valid && (cdb_tag == in_src2);

	// Wakeup for a waiting slot
	assign src1_hit = cdb_valid && (cdb_tag == src1);
	assign src2_hit = cdb_valid && (cdb_tag == src2);

	////////////////////////////////
	// Control state
	////////////////////////////////

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			busy     <= 1'b0;
			src1_rdy <= 1'b0;
			src2_rdy <= 1'b0;
		end else if (write) begin
			// New instruction, pick up a same-cycle broadcast
			busy     <= 1'b1;
			src1_rdy <= in_src1_ready | in_src1_hit;
			src2_rdy <= in_src2_ready | in_src2_hit;
		end else begin
			// Released by the issue selector
			if (free)
				busy <= 1'b0;
			// Sticky wakeup
			if (src1_hit)
				src1_rdy <= 1'b1;
			if (src2_hit)
				src2_rdy <= 1'b1;
		end
	end

	// Payload, loaded on allocation only
	always_ff @(posedge clock) begin
		if (write) begin
			func <= in_func;
			dest <= in_dest;
			src1 <= in_src1;
			src2 <= in_src2;
		end
	end

	// Eligible for issue once both operands are available
	assign ready = busy & src1_rdy & src2_rdy;

endmodule

`default_nettype wire

// ==== src/rs_pkg.sv ====
// Reservation station package
// Functional-unit class and ALU function enums, tag width, slot to class map

`default_nettype none

`include "rs_cfg.svh"

package rs_pkg;

	// Physical tag width
	localparam int TAG_W = $clog2(`RS_NUM_PR);

	// Class encoding, doubles as class index
	typedef enum logic [2:0] {
		fu_ld   = 3'd0,
		fu_st   = 3'd1,
		fu_br   = 3'd2,
		fu_mult = 3'd3,
		fu_alu  = 3'd4
	} fu_t;

	// ALU operations
	typedef enum logic [4:0] {
		alu_addq   = 5'h00,
		alu_subq   = 5'h01,
		alu_and    = 5'h02,
		alu_bic    = 5'h03,
		alu_bis    = 5'h04,
		alu_ornot  = 5'h05,
		alu_xor    = 5'h06,
		alu_eqv    = 5'h07,
		alu_srl    = 5'h08,
		alu_sll    = 5'h09,
		alu_sra    = 5'h0a,
		alu_mulq   = 5'h0b,
		alu_cmpeq  = 5'h0c,
		alu_cmplt  = 5'h0d,
		alu_cmple  = 5'h0e,
		alu_cmpult = 5'h0f,
		alu_cmpule = 5'h10
	} alu_func_t;

	// Slot index to class, grouping is ld, st, br, mult, alu
	function automatic fu_t class_of(input int idx);
		if (idx < `RS_NUM_LD)
			return fu_ld;
		else if (idx < `RS_NUM_LD + `RS_NUM_ST)
			return fu_st;
		else if (idx < `RS_NUM_LD + `RS_NUM_ST + `RS_NUM_BR)
			return fu_br;
		else if (idx < `RS_NUM_LD + `RS_NUM_ST + `RS_NUM_BR + `RS_NUM_MULT)
			return fu_mult;
		else
			return fu_alu;
	endfunction

endpackage

`default_nettype wire

// ==== src/rs_cfg.svh ====
// Reservation station sizing macros
// Physical register count and entries per functional-unit class

`ifndef RS_CFG_SVH
`define RS_CFG_SVH

// Physical register file size, sets the tag width
`define RS_NUM_PR 64

// Entries per class, in slot order
`define RS_NUM_LD 1
`define RS_NUM_ST 1
`define RS_NUM_BR 1
`define RS_NUM_MULT 2
`define RS_NUM_ALU 3

// Total slots across all classes
`define RS_NUM_ENTRY (`RS_NUM_LD + `RS_NUM_ST + `RS_NUM_BR + `RS_NUM_MULT + `RS_NUM_ALU)

// Number of functional-unit classes
`define RS_NUM_FU 5

`endif
